// File: dma_defines.svh
// Register map constants for the DMA register-file endpoint.
// The host window is 4 bytes per register, 2^DMA_ADDR_WIDTH registers wide.
// The channel and index widths must add up to DMA_ADDR_WIDTH.
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Host byte address of register 0
`define DMA_BASE_ADDRESS 32'h43c0_0000

`define DMA_BUS_WIDTH 32
`define DMA_DATA_WIDTH 20
`define DMA_ADDR_WIDTH 8

// Upper address bits select the channel, lower bits the word inside it
`define DMA_CHANNEL_BITS 3
`define DMA_N_CHANNELS (1 << `DMA_CHANNEL_BITS)
`define DMA_INDEX_BITS 5
`define DMA_BANK_DEPTH (1 << `DMA_INDEX_BITS)

// Wide enough to hold a count of DMA_N_CHANNELS itself
`define DMA_COUNT_BITS 4

`endif

// File: dma_pkg.sv
// Shared types of the DMA register-file endpoint.
// Register address 0 is reserved for the channel count.
`include "dma_defines.svh"

package dma_pkg;

    // The same address word seen as a flat register number or as channel/index
    typedef union packed {
        logic [`DMA_ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [`DMA_CHANNEL_BITS-1:0] channel;
            logic [`DMA_INDEX_BITS-1:0] index;
        } fields;
    } reg_addr_t;

    // One-cycle request from the host bus side
    typedef struct packed {
        logic write_strobe;
        logic read_strobe;
        reg_addr_t address;
        logic [`DMA_DATA_WIDTH-1:0] data;
    } bus_request_t;

    // Write broadcast to every channel bank
    typedef struct packed {
        logic valid;
        reg_addr_t address;
        logic [`DMA_DATA_WIDTH-1:0] data;
    } reg_write_t;

    typedef struct packed {
        logic valid;
        logic [`DMA_DATA_WIDTH-1:0] data;
    } read_response_t;

endpackage

// File: bus_register_port.sv
// Host bus front end. Accesses outside the register window are dropped
// silently. The two low address bits are ignored, so byte addresses are
// word aligned. Upper data bits beyond the register width are discarded.
`timescale 1ns/1ps
`include "dma_defines.svh"

module bus_register_port
    import dma_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [`DMA_BUS_WIDTH-1:0] bus_address,
    input  logic bus_write_strobe,
    input  logic bus_read_strobe,
    input  logic [`DMA_BUS_WIDTH-1:0] bus_write_data,
    output bus_request_t host_request
);

    // Size of the register window in bytes
    localparam logic [`DMA_BUS_WIDTH-1:0] WINDOW_BYTES = 1 << (`DMA_ADDR_WIDTH + 2);

    logic [`DMA_BUS_WIDTH-1:0] byte_offset;
    logic in_window;
    reg_addr_t word_address;

    // Addresses below the base wrap to a large offset and fail the window check
    assign byte_offset = bus_address - `DMA_BASE_ADDRESS;
    assign in_window = byte_offset < WINDOW_BYTES;
    assign word_address.raw = byte_offset[`DMA_ADDR_WIDTH+1:2];

    always_ff @(posedge clock) begin
        if (!reset) begin
            host_request.write_strobe <= 1'b0;
            host_request.read_strobe <= 1'b0;
        end else begin
            host_request.write_strobe <= bus_write_strobe && in_window;
            host_request.read_strobe <= bus_read_strobe && in_window;
        end
    end

    // Address and data are only meaningful alongside a strobe
    always_ff @(posedge clock) begin
        host_request.address <= word_address;
        host_request.data <= bus_write_data[`DMA_DATA_WIDTH-1:0];
    end

endmodule

// File: dma_endpoint.sv
// Arbitration and read sequencing for the register file.
// Stream writes win over host writes in the same cycle, the host write is lost.
// Only one read is in flight at a time. Host reads arriving while busy are lost.
// Register 0 holds the channel count, clamped to the number of banks.
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_endpoint
    import dma_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  bus_request_t host_request,
    input  logic stream_write_valid,
    input  reg_addr_t stream_write_dest,
    input  logic [`DMA_DATA_WIDTH-1:0] stream_write_data,
    input  logic stream_request_valid,
    input  reg_addr_t stream_request_addr,
    input  read_response_t collected,
    output logic stream_request_ready,
    output reg_write_t bank_write,
    output reg_addr_t read_addr,
    output logic [`DMA_COUNT_BITS-1:0] n_channels,
    output logic [`DMA_BUS_WIDTH-1:0] bus_read_data,
    output logic bus_read_valid,
    output read_response_t stream_response
);

    typedef enum logic [1:0] {
        state_idle,
        state_read_wait,
        state_host_respond,
        state_stream_respond
    } state_t;

    state_t state;
    logic from_stream;
    logic count_read;

    logic arb_valid;
    reg_addr_t arb_address;
    logic [`DMA_DATA_WIDTH-1:0] arb_data;
    logic arb_is_count;
    logic arb_channel_active;

    logic stream_accept;
    logic host_bank_read;
    logic [`DMA_DATA_WIDTH-1:0] response_word;

    // Write source selection, stream side first
    always_comb begin
        if (stream_write_valid) begin
            arb_valid = 1'b1;
            arb_address = stream_write_dest;
            arb_data = stream_write_data;
        end else begin
            arb_valid = host_request.write_strobe;
            arb_address = host_request.address;
            arb_data = host_request.data;
        end
    end

    assign arb_is_count = arb_address.raw == '0;
    assign arb_channel_active = {1'b0, arb_address.fields.channel} < n_channels;

    always_ff @(posedge clock) begin
        if (!reset) begin
            bank_write.valid <= 1'b0;
            n_channels <= '0;
        end else begin
            bank_write.valid <= arb_valid && !arb_is_count && arb_channel_active;
            bank_write.address <= arb_address;
            bank_write.data <= arb_data;
            if (arb_valid && arb_is_count) begin
                if (arb_data > `DMA_N_CHANNELS) begin
                    n_channels <= `DMA_COUNT_BITS'(`DMA_N_CHANNELS);
                end else begin
                    n_channels <= arb_data[`DMA_COUNT_BITS-1:0];
                end
            end
        end
    end

    assign stream_request_ready = state == state_idle;
    assign stream_accept = stream_request_valid && stream_request_ready;

    // A stream request in the same idle cycle takes the read path
    assign host_bank_read = host_request.read_strobe && host_request.address.raw != '0
        && stream_request_ready && !stream_accept;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= state_idle;
            from_stream <= 1'b0;
            read_addr <= '0;
            count_read <= 1'b0;
        end else begin
            // The count needs no bank access and is answered on the next cycle
            count_read <= host_request.read_strobe && host_request.address.raw == '0
                && stream_request_ready;
            case (state)
                state_idle: begin
                    if (stream_accept) begin
                        read_addr <= stream_request_addr;
                        from_stream <= 1'b1;
                        state <= state_read_wait;
                    end else if (host_bank_read) begin
                        read_addr <= host_request.address;
                        from_stream <= 1'b0;
                        state <= state_read_wait;
                    end
                end
                state_read_wait: begin
                    state <= from_stream ? state_stream_respond : state_host_respond;
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // A stream read of register 0 gets the count instead of bank 0 word 0
    always_comb begin
        if (read_addr.raw == '0) begin
            response_word = `DMA_DATA_WIDTH'(n_channels);
        end else if (collected.valid) begin
            response_word = collected.data;
        end else begin
            response_word = '0;
        end
    end

    assign bus_read_valid = count_read || state == state_host_respond;
    assign bus_read_data = count_read ? `DMA_BUS_WIDTH'(n_channels)
                                      : `DMA_BUS_WIDTH'(response_word);

    assign stream_response.valid = state == state_stream_respond;
    assign stream_response.data = response_word;

endmodule

// File: channel_bank.sv
// Register storage of one channel. All words clear on reset.
// Writes for other channels are ignored, the read port is combinational.
`timescale 1ns/1ps
`include "dma_defines.svh"

module channel_bank
    import dma_pkg::*;
#(
    parameter int CHANNEL = 0
) (
    input  logic clock,
    input  logic reset,
    input  reg_write_t bank_write,
    input  reg_addr_t read_addr,
    output logic [`DMA_DATA_WIDTH-1:0] read_word
);

    logic [`DMA_DATA_WIDTH-1:0] words [`DMA_BANK_DEPTH];
    logic write_hit;

    assign write_hit = bank_write.valid
        && bank_write.address.fields.channel == `DMA_CHANNEL_BITS'(CHANNEL);

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `DMA_BANK_DEPTH; i++) begin
                words[i] <= '0;
            end
        end else if (write_hit) begin
            words[bank_write.address.fields.index] <= bank_write.data;
        end
    end

    // Every bank shows its word at the index, the collector picks the channel
    assign read_word = words[read_addr.fields.index];

endmodule

// File: read_collector.sv
// Registered read mux across all channel banks.
// Channels at or above the active count read as zero with valid low.
`timescale 1ns/1ps
`include "dma_defines.svh"

module read_collector
    import dma_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  reg_addr_t read_addr,
    input  logic [`DMA_N_CHANNELS-1:0][`DMA_DATA_WIDTH-1:0] bank_words,
    input  logic [`DMA_COUNT_BITS-1:0] n_channels,
    output read_response_t collected
);

    logic channel_active;

    assign channel_active = {1'b0, read_addr.fields.channel} < n_channels;

    always_ff @(posedge clock) begin
        if (!reset) begin
            collected.valid <= 1'b0;
            collected.data <= '0;
        end else begin
            // Valid marks a word that came from an active bank
            collected.valid <= channel_active;
            if (channel_active) begin
                collected.data <= bank_words[read_addr.fields.channel];
            end else begin
                collected.data <= '0;
            end
        end
    end

endmodule

// File: dma_subsystem.sv
// Register-file endpoint top level for the DSP core.
// The host bus has no wait states and no byte enables. Stream writes have no
// backpressure. Stream read requests need stream_request_ready high.
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_subsystem
    import dma_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [`DMA_BUS_WIDTH-1:0] bus_address,
    input  logic bus_write_strobe,
    input  logic bus_read_strobe,
    input  logic [`DMA_BUS_WIDTH-1:0] bus_write_data,
    output logic [`DMA_BUS_WIDTH-1:0] bus_read_data,
    output logic bus_read_valid,
    input  logic stream_write_valid,
    input  reg_addr_t stream_write_dest,
    input  logic [`DMA_DATA_WIDTH-1:0] stream_write_data,
    input  logic stream_request_valid,
    input  reg_addr_t stream_request_addr,
    output logic stream_request_ready,
    output read_response_t stream_response,
    output logic [`DMA_COUNT_BITS-1:0] n_channels
);

    bus_request_t host_request;
    reg_write_t bank_write;
    reg_addr_t read_addr;
    read_response_t collected;
    logic [`DMA_N_CHANNELS-1:0][`DMA_DATA_WIDTH-1:0] bank_words;

    bus_register_port port0 (
        .clock(clock),
        .reset(reset),
        .bus_address(bus_address),
        .bus_write_strobe(bus_write_strobe),
        .bus_read_strobe(bus_read_strobe),
        .bus_write_data(bus_write_data),
        .host_request(host_request)
    );

    dma_endpoint endpoint0 (
        .clock(clock),
        .reset(reset),
        .host_request(host_request),
        .stream_write_valid(stream_write_valid),
        .stream_write_dest(stream_write_dest),
        .stream_write_data(stream_write_data),
        .stream_request_valid(stream_request_valid),
        .stream_request_addr(stream_request_addr),
        .collected(collected),
        .stream_request_ready(stream_request_ready),
        .bank_write(bank_write),
        .read_addr(read_addr),
        .n_channels(n_channels),
        .bus_read_data(bus_read_data),
        .bus_read_valid(bus_read_valid),
        .stream_response(stream_response)
    );

    // One bank per channel, each keyed by its loop index
    for (genvar g = 0; g < `DMA_N_CHANNELS; g++) begin : gen_bank
        channel_bank #(
            .CHANNEL(g)
        ) bank (
            .clock(clock),
            .reset(reset),
            .bank_write(bank_write),
            .read_addr(read_addr),
            .read_word(bank_words[g])
        );
    end

    read_collector collector0 (
        .clock(clock),
        .reset(reset),
        .read_addr(read_addr),
        .bank_words(bank_words),
        .n_channels(n_channels),
        .collected(collected)
    );

endmodule

// File: tb_dma_subsystem.sv
// Testbench for the DMA register-file endpoint.
// Reads are issued one at a time with the endpoint idle, since a busy endpoint drops them.
// Channel counts written here stay within 0 to 8.
`timescale 1ns/1ps
`include "dma_defines.svh"

module tb_dma_subsystem
    import dma_pkg::*;
();

    localparam int TIMEOUT = 20;

    logic clock;
    logic reset;
    logic [`DMA_BUS_WIDTH-1:0] bus_address;
    logic bus_write_strobe;
    logic bus_read_strobe;
    logic [`DMA_BUS_WIDTH-1:0] bus_write_data;
    logic [`DMA_BUS_WIDTH-1:0] bus_read_data;
    logic bus_read_valid;
    logic stream_write_valid;
    reg_addr_t stream_write_dest;
    logic [`DMA_DATA_WIDTH-1:0] stream_write_data;
    logic stream_request_valid;
    reg_addr_t stream_request_addr;
    logic stream_request_ready;
    read_response_t stream_response;
    logic [`DMA_COUNT_BITS-1:0] n_channels;

    // Reference copy of every register and of the channel count
    logic [`DMA_DATA_WIDTH-1:0] model_words [1 << `DMA_ADDR_WIDTH];
    logic [`DMA_COUNT_BITS-1:0] model_count;
    int errors;
    int checks;
    logic [`DMA_BUS_WIDTH-1:0] host_offset;
    logic host_in_window;
    logic host_is_count;

    dma_subsystem dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    assign host_offset = bus_address - `DMA_BASE_ADDRESS;
    assign host_in_window = host_offset < (32'd4 << `DMA_ADDR_WIDTH);
    assign host_is_count = host_offset[`DMA_ADDR_WIDTH+1:2] == '0;

    // The count is answered straight from the endpoint, one cycle after the port
    assert property (@(posedge clock) disable iff (!reset)
        bus_read_strobe && host_in_window && host_is_count
        |-> ##2 bus_read_valid ##1 !bus_read_valid)
    else begin
        errors++;
        $display("Host read of the channel count answered at the wrong cycle, %0t", $time);
    end

    assert property (@(posedge clock) disable iff (!reset)
        bus_read_strobe && host_in_window && !host_is_count && stream_request_ready
        |-> ##2 (!stream_request_ready && !bus_read_valid)
        ##1 (!stream_request_ready && bus_read_valid)
        ##1 (stream_request_ready && !bus_read_valid))
    else begin
        errors++;
        $display("Host register read timing or ready level wrong, %0t", $time);
    end

    assert property (@(posedge clock) disable iff (!reset)
        stream_request_valid && stream_request_ready
        |-> ##1 (!stream_request_ready && !stream_response.valid)
        ##1 (!stream_request_ready && stream_response.valid)
        ##1 (stream_request_ready && !stream_response.valid))
    else begin
        errors++;
        $display("Stream read timing or ready level wrong, %0t", $time);
    end

    assert property (@(posedge clock) disable iff (!reset)
        bus_read_strobe && !host_in_window
        |-> ##1 !bus_read_valid ##1 !bus_read_valid ##1 !bus_read_valid)
    else begin
        errors++;
        $display("Host read outside the register window got a response, %0t", $time);
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [31:0] byte_address(input reg_addr_t address);
        return `DMA_BASE_ADDRESS + {22'b0, address.raw, 2'b00};
    endfunction

    function automatic logic [31:0] expected_word(input reg_addr_t address);
        if (address.raw == '0) begin
            return 32'(model_count);
        end
        if ({1'b0, address.fields.channel} >= model_count) begin
            return '0;
        end
        return 32'(model_words[address.raw]);
    endfunction

    // Register 0 takes the count, writes to inactive channels are dropped
    function automatic void model_write(input reg_addr_t address,
                                        input logic [`DMA_DATA_WIDTH-1:0] data);
        if (address.raw == '0) begin
            model_count = data[`DMA_COUNT_BITS-1:0];
        end else if ({1'b0, address.fields.channel} < model_count) begin
            model_words[address.raw] = data;
        end
    endfunction

    // Random register in channels low to high-1, never register 0
    function automatic reg_addr_t pick_address(input int low, input int high);
        reg_addr_t address;
        address.fields.channel = `DMA_CHANNEL_BITS'(low + int'($urandom % 32'(high - low)));
        address.fields.index = `DMA_INDEX_BITS'($urandom);
        if (address.raw == '0) begin
            address.fields.index = 1;
        end
        return address;
    endfunction

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!stream_request_ready && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!stream_request_ready) begin
            errors++;
            $display("Timeout waiting for stream_request_ready to return high");
        end
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            checks++;
            assert (!bus_read_valid && !stream_response.valid) else begin
                errors++;
                $display("A read response appeared where none was requested, %0t", $time);
            end
        end
    endtask

    task automatic host_write(input reg_addr_t address, input logic [`DMA_DATA_WIDTH-1:0] data);
        @(posedge clock);
        bus_address <= byte_address(address);
        // Upper bus bits carry junk that the port must drop
        bus_write_data <= {12'($urandom), data};
        bus_write_strobe <= 1'b1;
        @(posedge clock);
        bus_write_strobe <= 1'b0;
        model_write(address, data);
        repeat (2) @(posedge clock);
    endtask

    task automatic stream_write(input reg_addr_t address,
                                input logic [`DMA_DATA_WIDTH-1:0] data);
        @(posedge clock);
        stream_write_valid <= 1'b1;
        stream_write_dest <= address;
        stream_write_data <= data;
        @(posedge clock);
        stream_write_valid <= 1'b0;
        model_write(address, data);
        @(posedge clock);
    endtask

    // With poke set, a stream request is raised for one cycle while ready is low
    task automatic host_read(input reg_addr_t address, input bit poke);
        int cycles;
        wait_ready();
        @(posedge clock);
        bus_address <= byte_address(address);
        bus_read_strobe <= 1'b1;
        @(posedge clock);
        bus_read_strobe <= 1'b0;
        if (poke) begin
            @(posedge clock);
            stream_request_valid <= 1'b1;
            stream_request_addr <= address;
            @(posedge clock);
            stream_request_valid <= 1'b0;
        end
        cycles = 0;
        @(negedge clock);
        while (!bus_read_valid && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!bus_read_valid) begin
            errors++;
            $display("Timeout waiting for bus_read_valid, register %0d", address.raw);
        end else begin
            check_value("bus_read_data", expected_word(address), bus_read_data);
        end
    endtask

    task automatic stream_read(input reg_addr_t address);
        int cycles;
        wait_ready();
        @(posedge clock);
        stream_request_valid <= 1'b1;
        stream_request_addr <= address;
        @(posedge clock);
        stream_request_valid <= 1'b0;
        cycles = 0;
        @(negedge clock);
        while (!stream_response.valid && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!stream_response.valid) begin
            errors++;
            $display("Timeout waiting for stream_response, register %0d", address.raw);
        end else begin
            check_value("stream_response.data", expected_word(address),
                        32'(stream_response.data));
        end
    endtask

    // A write and a read outside the window, neither may touch the registers
    task automatic outside_access(input logic [31:0] address);
        @(posedge clock);
        bus_address <= address;
        bus_write_data <= '0;
        bus_write_strobe <= 1'b1;
        @(posedge clock);
        bus_write_strobe <= 1'b0;
        bus_read_strobe <= 1'b1;
        @(posedge clock);
        bus_read_strobe <= 1'b0;
        expect_silence(TIMEOUT);
        check_value("n_channels", 32'(model_count), 32'(n_channels));
    endtask

    initial begin
        reg_addr_t address;
        reg_addr_t other;
        reg_addr_t written [$];
        reg_addr_t dropped [$];
        logic [`DMA_DATA_WIDTH-1:0] data;
        void'($urandom(32'hb139));
        errors = 0;
        checks = 0;
        reset = 1'b0;
        bus_address = '0;
        bus_write_strobe = 1'b0;
        bus_read_strobe = 1'b0;
        bus_write_data = '0;
        stream_write_valid = 1'b0;
        stream_write_dest = '0;
        stream_write_data = '0;
        stream_request_valid = 1'b0;
        stream_request_addr = '0;
        for (int i = 0; i < (1 << `DMA_ADDR_WIDTH); i++) begin
            model_words[i] = '0;
        end
        model_count = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b1;

        @(negedge clock);
        check_value("n_channels", 32'd0, 32'(n_channels));
        check_value("stream_request_ready", 32'd1, 32'(stream_request_ready));
        expect_silence(3);
        host_read(pick_address(0, `DMA_N_CHANNELS), 1'b0);

        // Leave at least one channel inactive for the drop checks
        host_write('0, `DMA_DATA_WIDTH'(2 + $urandom % 6));
        @(negedge clock);
        check_value("n_channels", 32'(model_count), 32'(n_channels));
        host_read('0, 1'b0);
        stream_read('0);

        // An active register that was never written still holds its reset value
        host_read(pick_address(0, int'(model_count)), 1'b0);

        repeat (16) begin
            address = pick_address(0, int'(model_count));
            host_write(address, `DMA_DATA_WIDTH'($urandom));
            written.push_back(address);
        end
        foreach (written[i]) begin
            host_read(written[i], 1'b0);
        end

        repeat (12) begin
            address = pick_address(0, int'(model_count));
            stream_write(address, `DMA_DATA_WIDTH'($urandom));
            stream_read(address);
        end
        host_read(pick_address(0, int'(model_count)), 1'b1);
        expect_silence(TIMEOUT);

        repeat (6) begin
            address = pick_address(int'(model_count), `DMA_N_CHANNELS);
            host_write(address, `DMA_DATA_WIDTH'($urandom));
            stream_write(address, `DMA_DATA_WIDTH'($urandom));
            host_read(address, 1'b0);
            stream_read(address);
            dropped.push_back(address);
        end

        // Once every channel is active, the dropped writes must not show up
        host_write('0, `DMA_DATA_WIDTH'(`DMA_N_CHANNELS));
        foreach (dropped[i]) begin
            host_read(dropped[i], 1'b0);
        end

        outside_access(`DMA_BASE_ADDRESS + (32'd4 << `DMA_ADDR_WIDTH));
        outside_access(`DMA_BASE_ADDRESS - 32'd4);

        // The host write reaches the endpoint one cycle after its bus strobe,
        // so the stream write is driven one cycle later to meet it there
        address = pick_address(0, int'(model_count));
        do begin
            other = pick_address(0, int'(model_count));
        end while (other == address);
        data = `DMA_DATA_WIDTH'($urandom);
        @(posedge clock);
        bus_address <= byte_address(address);
        bus_write_data <= 32'($urandom);
        bus_write_strobe <= 1'b1;
        @(posedge clock);
        bus_write_strobe <= 1'b0;
        stream_write_valid <= 1'b1;
        stream_write_dest <= other;
        stream_write_data <= data;
        @(posedge clock);
        stream_write_valid <= 1'b0;
        model_write(other, data);
        host_read(address, 1'b0);
        host_read(other, 1'b0);

        repeat (2) @(posedge clock);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
dma_pkg.sv
bus_register_port.sv
dma_endpoint.sv
channel_bank.sv
read_collector.sv
dma_subsystem.sv
tb_dma_subsystem.sv

// File: Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dma_subsystem
FILELIST  ?= filelist.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) dma_defines.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
